//--- common/cpuConfig.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// width of one instruction word
`define CPU_INSTR_WIDTH 16

// instruction queue entries, which is also the sender's starting credit count
`define CPU_QUEUE_DEPTH 2

// credits held by the fetch source after reset
`define CPU_INIT_CREDITS `CPU_QUEUE_DEPTH

`endif

//--- common/opxPkg.sv
package opxPkg;

	// top two instruction bits
	typedef enum logic [1:0] {
		GROUP_SYSTEM      = 2'd0,
		GROUP_LOAD_STORE  = 2'd1,
		GROUP_JUMP        = 2'd2,
		GROUP_ARITH_LOGIC = 2'd3
	} instrGroup_t;

	typedef enum logic [3:0] {
		ALU_OPX_MOV = 4'd0,
		ALU_OPX_ADD = 4'd1,
		ALU_OPX_SUB = 4'd2,
		ALU_OPX_AND = 4'd3,
		ALU_OPX_OR  = 4'd4,
		ALU_OPX_XOR = 4'd5,
		ALU_OPX_INC = 4'd6,
		ALU_OPX_DEC = 4'd7,
		ALU_OPX_NOT = 4'd8,
		ALU_OPX_SHL = 4'd9,
		ALU_OPX_SHR = 4'd10
	} aluOpx_t;

	typedef enum logic [1:0] {
		ALUA_CONSTX_ZERO = 2'd0,
		ALUA_CONSTX_ONE  = 2'd1,
		ALUA_CONSTX_TWO  = 2'd2,
		ALUA_CONSTX_FOUR = 2'd3
	} aluAConstx_t;

	typedef enum logic {ALUA_SRCX_REG_A = 1'b0, ALUA_SRCX_CONST = 1'b1} aluASrcx_t;

	typedef enum logic [2:0] {
		ALUB_SRCX_REG_B     = 3'd0,
		ALUB_SRCX_PC        = 3'd1,
		ALUB_SRCX_PC_OFFSET = 3'd2,
		ALUB_SRCX_IMM8      = 3'd3,
		ALUB_SRCX_IMM4      = 3'd4
	} aluBSrcx_t;

	typedef enum logic [1:0] {REGA_DINX_ALU_R, REGA_DINX_DATA_BUS, REGA_DINX_PC} regADinx_t;

	typedef enum logic [1:0] {DATA_BUSX_ALU, DATA_BUSX_REG_A, DATA_BUSX_REG_B, DATA_BUSX_PC} dataBusx_t;

	typedef enum logic [1:0] {ADDR_BUSX_PC, ADDR_BUSX_REG_B, ADDR_BUSX_REG_A, ADDR_BUSX_ALU_R} addrBusx_t;

	// one phase bit set at a time
	typedef enum logic [3:0] {
		PHASE_FETCH   = 4'b0001,
		PHASE_DECODE  = 4'b0010,
		PHASE_EXECUTE = 4'b0100,
		PHASE_COMMIT  = 4'b1000
	} phase_t;

	typedef struct packed {
		logic        regAEn;
		logic        regBEn;
		logic        regAWen;
		logic        regBWen;
		aluOpx_t     aluOpx;
		logic        aluLd;
		aluAConstx_t aluAConstx;
		aluASrcx_t   aluASrcx;
		aluBSrcx_t   aluBSrcx;
		regADinx_t   regADinx;
		logic [2:0]  regAAddrx;
		logic [1:0]  regBAddrx;
		dataBusx_t   dataBusx;
		logic        dataBusOen;
		addrBusx_t   addrBusx;
	} controlWord_t;

	typedef struct packed {
		aluBSrcx_t  aluBSrcx;
		logic [1:0] regBAddrx;
	} jumpSelect_t;

endpackage

//--- design/instrQueue.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module instrQueue (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	input  logic                        instrValid,
	input  logic                        pop,
	output logic [`CPU_INSTR_WIDTH-1:0] head,
	output logic                        notEmpty
);
	localparam int PTR_W = (`CPU_QUEUE_DEPTH > 1) ? $clog2(`CPU_QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(`CPU_QUEUE_DEPTH + 1);

	logic [`CPU_INSTR_WIDTH-1:0] mem [0:`CPU_QUEUE_DEPTH-1];
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W-1:0] wrPtr;
	logic [CNT_W-1:0] count;
	logic doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(`CPU_QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPop = pop & notEmpty; // popping an empty queue is ignored
	assign notEmpty = (count != '0);
	assign head = mem[rdPtr];

	always_ff @(posedge CLK) begin
		if (reset) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (instrValid) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			case ({instrValid, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credits keep the sender from writing while full
	always_ff @(posedge CLK) begin
		if (instrValid) mem[wrPtr] <= instr;
	end

endmodule

//--- decode/aluGroupDecoder.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module aluGroupDecoder (
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	output opxPkg::controlWord_t        word
);
	import opxPkg::*;

	aluOpx_t opx;
	logic    isCompare;
	logic    useConst;

	assign opx = aluOpx_t'(instr[13:10]);
	assign isCompare = (opx == ALU_OPX_SUB) && instr[0]; // compare only sets flags
	assign useConst = instr[4];

	always_comb begin
		word.regAEn     = 1'b1;
		word.regBEn     = 1'b1;
		word.regAWen    = ~isCompare;
		word.regBWen    = 1'b0;
		word.aluOpx     = opx;
		word.aluLd      = instr[1];
		word.aluAConstx = useConst ? aluAConstx_t'(instr[3:2]) : ALUA_CONSTX_ONE;
		word.aluASrcx   = useConst ? ALUA_SRCX_CONST : ALUA_SRCX_REG_A;
		word.aluBSrcx   = ALUB_SRCX_REG_B;
		word.regADinx   = REGA_DINX_ALU_R;
		word.regAAddrx  = instr[9:7];
		word.regBAddrx  = instr[6:5];

		// the result stays inside the core so the data bus is left alone
		word.dataBusx   = DATA_BUSX_ALU;
		word.dataBusOen = 1'b0;
		word.addrBusx   = ADDR_BUSX_PC;
	end

endmodule

//--- decode/ldsGroupDecoder.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module ldsGroupDecoder (
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	output opxPkg::controlWord_t        word
);
	import opxPkg::*;

	logic isStore;

	assign isStore = instr[13];

	always_comb begin
		word.regAEn     = 1'b1;
		word.regBEn     = 1'b1; // register B supplies the address
		word.regAWen    = ~isStore;
		word.regBWen    = 1'b0;
		word.aluOpx     = ALU_OPX_MOV;
		word.aluLd      = 1'b0;
		word.aluAConstx = ALUA_CONSTX_ONE;
		word.aluASrcx   = ALUA_SRCX_REG_A;
		word.aluBSrcx   = ALUB_SRCX_REG_B;
		word.regADinx   = isStore ? REGA_DINX_ALU_R : REGA_DINX_DATA_BUS;
		word.regAAddrx  = instr[12:10];
		word.regBAddrx  = instr[9:8];
		word.dataBusx   = isStore ? DATA_BUSX_REG_A : DATA_BUSX_ALU;
		word.dataBusOen = isStore;
		word.addrBusx   = ADDR_BUSX_REG_B;
	end

endmodule

//--- decode/jumpGroupDecoder.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module jumpGroupDecoder (
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	output opxPkg::jumpSelect_t         sel
);
	import opxPkg::*;

	logic isRelative;

	assign isRelative = instr[13];

	always_comb begin
		// relative jumps add the offset to the PC, absolute ones take register B
		sel.aluBSrcx  = isRelative ? ALUB_SRCX_PC_OFFSET : ALUB_SRCX_REG_B;
		sel.regBAddrx = instr[12:11];
	end

endmodule

//--- decode/opxMultiplexer.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module opxMultiplexer (
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	input  opxPkg::controlWord_t        aluWord,
	input  opxPkg::controlWord_t        ldsWord,
	input  opxPkg::jumpSelect_t         jumpSel,
	output opxPkg::controlWord_t        word
);
	import opxPkg::*;

	instrGroup_t  group;
	controlWord_t idleWord;

	assign group = instrGroup_t'(instr[`CPU_INSTR_WIDTH-1 -: 2]);

	// nothing is enabled, the datapath just idles
	always_comb begin
		idleWord.regAEn     = 1'b0;
		idleWord.regBEn     = 1'b0;
		idleWord.regAWen    = 1'b0;
		idleWord.regBWen    = 1'b0;
		idleWord.aluOpx     = ALU_OPX_MOV;
		idleWord.aluLd      = 1'b0;
		idleWord.aluAConstx = ALUA_CONSTX_ONE;
		idleWord.aluASrcx   = ALUA_SRCX_REG_A;
		idleWord.aluBSrcx   = ALUB_SRCX_REG_B;
		idleWord.regADinx   = REGA_DINX_ALU_R;
		idleWord.regAAddrx  = 3'd0;
		idleWord.regBAddrx  = 2'd0;
		idleWord.dataBusx   = DATA_BUSX_ALU;
		idleWord.dataBusOen = 1'b0;
		idleWord.addrBusx   = ldsWord.addrBusx; // address bus keeps the load/store source
	end

	always_comb begin
		case (group)
			GROUP_LOAD_STORE:  word = ldsWord;
			GROUP_ARITH_LOGIC: word = aluWord;
			GROUP_JUMP: begin
				word           = idleWord;
				word.aluBSrcx  = jumpSel.aluBSrcx;
				word.regBAddrx = jumpSel.regBAddrx;
			end
			default:           word = idleWord; // system group only idles
		endcase
	end

endmodule

//--- design/phaseSequencer.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module phaseSequencer (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic                        notEmpty,
	input  logic [`CPU_INSTR_WIDTH-1:0] head,
	output logic                        pop,
	output logic [`CPU_INSTR_WIDTH-1:0] curInstr,
	input  opxPkg::controlWord_t        muxWord,
	output opxPkg::phase_t              phase,
	output opxPkg::controlWord_t        ctrl,
	output logic                        ctrlValid,
	output logic                        creditReturn
);
	import opxPkg::*;

	phase_t nextPhase;

	assign pop = (phase == PHASE_FETCH) && notEmpty;
	assign ctrlValid = (phase == PHASE_EXECUTE);
	assign creditReturn = (phase == PHASE_COMMIT); // one credit per retired instruction

	always_comb begin
		case (phase)
			PHASE_FETCH:   nextPhase = notEmpty ? PHASE_DECODE : PHASE_FETCH;
			PHASE_DECODE:  nextPhase = PHASE_EXECUTE;
			PHASE_EXECUTE: nextPhase = PHASE_COMMIT;
			default:       nextPhase = PHASE_FETCH;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phase <= PHASE_FETCH;
			ctrl  <= '0;
		end else begin
			phase <= nextPhase;
			if (phase == PHASE_DECODE) ctrl <= muxWord; // held through execute
		end
	end

	// instruction stays put until the next fetch
	always_ff @(posedge CLK) begin
		if (pop) curInstr <= head;
	end

endmodule

//--- design/opxDecodeTop.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module opxDecodeTop (
	input  logic                        CLK,
	input  logic                        reset,
	input  logic [`CPU_INSTR_WIDTH-1:0] instr,
	input  logic                        instrValid,
	output opxPkg::controlWord_t        ctrl,
	output logic                        ctrlValid,
	output logic                        creditReturn,
	output opxPkg::phase_t              phase
);
	import opxPkg::*;

	logic [`CPU_INSTR_WIDTH-1:0] head;
	logic [`CPU_INSTR_WIDTH-1:0] curInstr;
	logic         notEmpty;
	logic         pop;
	controlWord_t aluWord;
	controlWord_t ldsWord;
	controlWord_t muxWord;
	jumpSelect_t  jumpSel;

	instrQueue queue (.CLK, .reset, .instr, .instrValid, .pop, .head, .notEmpty);

	phaseSequencer sequencer (
		.CLK, .reset, .notEmpty, .head, .pop, .curInstr,
		.muxWord, .phase, .ctrl, .ctrlValid, .creditReturn
	);

	// every group decoder sees the held instruction, the mux picks one
	aluGroupDecoder aluDecoder (.instr(curInstr), .word(aluWord));
	ldsGroupDecoder ldsDecoder (.instr(curInstr), .word(ldsWord));
	jumpGroupDecoder jumpDecoder (.instr(curInstr), .sel(jumpSel));

	opxMultiplexer groupMux (.instr(curInstr), .aluWord, .ldsWord, .jumpSel, .word(muxWord));

endmodule

//--- verif/opxDecodeTb.sv
`timescale 1ns/1ps
`include "cpuConfig.svh"

module opxDecodeTb;
	import opxPkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int IDLE_CYCLES = 3;
	localparam int MAX_VECTORS = 32;
	localparam int MARGIN_CYCLES = 40;

	logic                        CLK;
	logic                        reset;
	logic [`CPU_INSTR_WIDTH-1:0] instr;
	logic                        instrValid;
	controlWord_t                ctrl;
	logic                        ctrlValid;
	logic                        creditReturn;
	phase_t                      phase;

	// even entries hold instructions, odd entries the expected control words
	logic [31:0] vecMem [0:2*MAX_VECTORS-1];
	logic [31:0] expectQ [$];
	int numVectors;
	bit vectorsLoaded;
	int credits;
	int sent;
	int received;
	int returns;
	int gapLeft;
	logic prevCtrlValid;

	opxDecodeTop UUT (
		.CLK, .reset, .instr, .instrValid,
		.ctrl, .ctrlValid, .creditReturn, .phase
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	task automatic endWithFailure();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped on the first failure");
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, actual, expected);
			endWithFailure();
		end
	endtask

	// sender side of the credit loop, one call per falling edge
	task automatic collectCredit();
		if (creditReturn) begin
			credits++;
			returns++;
		end
		if (credits > `CPU_QUEUE_DEPTH) begin
			$display("The sender holds %0d credits, more than the queue depth", credits);
			endWithFailure();
		end
	endtask

	initial begin : watchdog
		int limit;
		wait (vectorsLoaded);
		limit = numVectors * 12 + RESET_CYCLES + IDLE_CYCLES + MARGIN_CYCLES;
		repeat (limit) @(posedge CLK);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		endWithFailure();
	end

	initial begin : stimulus
		int i;
		void'($urandom(90004));
		instr = '0;
		instrValid = 1'b0;
		reset = 1'b1;
		vectorsLoaded = 1'b0;

		// top bits set mark a slot the file did not fill
		for (i = 0; i < 2 * MAX_VECTORS; i++) begin
			vecMem[i] = 32'hF800_0000 | 32'(i);
		end
		$readmemh("verif/opxVectors.txt", vecMem);
		numVectors = 0;
		while (numVectors < MAX_VECTORS && vecMem[2*numVectors+1][31:27] == 5'd0) begin
			numVectors++;
		end
		if (numVectors == 0) begin
			$display("No vectors could be read from verif/opxVectors.txt");
			endWithFailure();
		end
		vectorsLoaded = 1'b1;

		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		repeat (IDLE_CYCLES) begin
			@(negedge CLK);
			compareValue("ctrlValid", 32'(ctrlValid), 32'd0);
			compareValue("creditReturn", 32'(creditReturn), 32'd0);
			compareValue("phase", 32'(phase), 32'(PHASE_FETCH));
			compareValue("ctrl", 32'(ctrl), 32'd0);
		end

		credits = `CPU_INIT_CREDITS;
		sent = 0;
		received = 0;
		returns = 0;
		prevCtrlValid = 1'b0;
		gapLeft = $urandom % 4;
		while (received < numVectors) begin
			@(negedge CLK);
			instrValid = 1'b0;
			// commit follows execute
			compareValue("creditReturn", 32'(creditReturn), 32'(prevCtrlValid));
			if (ctrlValid) begin
				if (expectQ.size() == 0) begin
					$display("ctrlValid went high with no instruction outstanding");
					endWithFailure();
				end
				compareValue("ctrl", 32'(ctrl), expectQ.pop_front());
				received++;
			end
			prevCtrlValid = ctrlValid;
			collectCredit();
			if (sent < numVectors) begin
				if (gapLeft > 0) begin
					gapLeft--;
				end else if (credits > 0) begin
					instr = vecMem[2*sent][`CPU_INSTR_WIDTH-1:0];
					instrValid = 1'b1;
					expectQ.push_back(vecMem[2*sent+1]);
					sent++;
					credits--;
					gapLeft = $urandom % 4;
				end
			end
		end

		// last commit, then the sequencer should settle in fetch
		repeat (3) begin
			@(negedge CLK);
			compareValue("creditReturn", 32'(creditReturn), 32'(prevCtrlValid));
			compareValue("ctrlValid", 32'(ctrlValid), 32'd0);
			prevCtrlValid = ctrlValid;
			collectCredit();
		end
		compareValue("creditReturn count", 32'(returns), 32'(numVectors));
		compareValue("phase", 32'(phase), 32'(PHASE_FETCH));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

//--- verif/opxVectors.txt
// columns: instruction word, expected control word (27-bit packed struct, zero extended)
// group by instr[15:14]: 0 system, 1 load/store, 2 jump, 3 arithmetic/logic
C5C2 070D01C0
CAA3 061502A0
CAA2 071502A0
5A3C 07010741
6DFF 060101AD
9555 00010041
A800 00012021
0000 00010001
D7FD 072B83E0
D812 07348000
4000 07010401
7F12 060103ED
BFFF 00012061
82AA 00010001
3FFF 00010001
C161 07010160
EA5B 07568240
C895 06118080
1234 00010001
CF21 07190320

//--- files.f
+incdir+common
common/opxPkg.sv
design/instrQueue.sv
decode/aluGroupDecoder.sv
decode/ldsGroupDecoder.sv
decode/jumpGroupDecoder.sv
decode/opxMultiplexer.sv
design/phaseSequencer.sv
design/opxDecodeTop.sv
verif/opxDecodeTb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := opxDecodeTb
RTL_TOP    := opxDecodeTop
FILELIST   := files.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
